//--- verilog.f
+incdir+design
design/pmp_pkg.sv
design/pmp_napot_decoder.sv
design/pmp_csr_file.sv
design/pmp_region_matcher.sv
design/pmp_access_check.sv
design/pmp_fault_recorder.sv
design/pmp_unit.sv
tb/pmp_clock_gen.sv
tb/pmp_unit_tb.sv

//--- Makefile
# Verilator build and run of the PMP unit testbench

VERILATOR ?= verilator
TOP       ?= pmp_unit_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= TESTBENCH PASSED

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) design/pmp_settings.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# The run fails unless the pass message shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- tb/pmp_cases.txt
# Hex columns: op f1 f2 f3 f4. 1 csr write (addr wdata mmode), 2 csr read (addr mmode rdata exists)
# 3 fetch (addr mmode kill), 4 data (addr mmode write kill), 5 fault (valid addr cause), 6 clear
5 0 0 0 0
3 123 0 1 0
4 456 0 0 1
3 123 1 0 0
4 456 1 1 0
5 1 123 0 0
1 3b0 41ff 1 0
1 3b1 800f 1 0
1 3b2 11fff 1 0
1 3b3 5fff 1 0
1 3b5 12345670 1 0
1 3a0 1f1c1b19 1 0
2 3a0 1 1f1c1b19 1
2 3b5 1 1234567f 1
2 3f0 1 0 0
2 3a0 0 1f1c1b19 0
1 3b6 201ff 1 0
1 3b7 3000f 1 0
1 3a1 1899720d 1 0
2 3a1 1 18990205 1
4 400 0 1 0
3 400 0 1 0
4 401 0 0 1
3 800 0 0 0
3 9ff 0 0 0
3 a00 0 1 0
4 900 0 0 1
4 210 0 1 1
4 220 0 1 0
3 21f 0 1 0
3 400 1 0 0
4 1000 1 1 1
3 1010 1 1 0
4 101f 0 0 0
1 3b6 0 1 0
2 3b6 1 201ff 1
1 3a1 181f0000 1 0
2 3a1 1 18990000 1
4 1800 1 1 0
4 1800 0 0 1
6 0 0 0 0
5 0 0 0 0
4 a00 0 1 1
5 1 a00 2 0
3 7ff 0 1 0
5 1 a00 2 0
6 0 0 0 0
5 0 0 0 0

//--- tb/pmp_unit_tb.sv
`default_nettype none
`include "pmp_settings.svh"

module pmp_unit_tb;

    logic                       core_clock;
    logic                       rst_n;
    logic [11:0]                csr_addr;
    logic [31:0]                csr_wdata;
    logic                       csr_we;
    logic                       csr_mmode;
    logic [31:0]                csr_rdata;
    logic                       csr_exists;
    logic [`PMP_ADDR_BITS-1:0]  fetch_addr;
    logic                       fetch_mmode;
    logic                       fetch_kill;
    logic [`PMP_ADDR_BITS-1:0]  data_addr;
    logic                       data_mmode;
    logic                       data_write;
    logic                       data_kill;
    logic                       fault_clear;
    logic                       fault_valid;
    logic [`PMP_ADDR_BITS-1:0]  fault_addr;
    logic [1:0]                 fault_cause;

    int          cases_run;
    int          cases_failed;
    bit          case_ok;
    bit          aborted;
    int          fd;
    int          fields;
    string       line;
    logic [31:0] op;
    logic [31:0] col1;
    logic [31:0] col2;
    logic [31:0] col3;
    logic [31:0] col4;

    pmp_clock_gen #(.HALF_PERIOD(20), .RESET_CYCLES(10)) clock_gen0 (
        .core_clock_o (core_clock),
        .rst_n_o      (rst_n)
    );

    pmp_unit dut0 (
        .core_clock_i  (core_clock),
        .rst_n_i       (rst_n),
        .csr_addr_i    (csr_addr),
        .csr_wdata_i   (csr_wdata),
        .csr_we_i      (csr_we),
        .csr_mmode_i   (csr_mmode),
        .csr_rdata_o   (csr_rdata),
        .csr_exists_o  (csr_exists),
        .fetch_addr_i  (fetch_addr),
        .fetch_mmode_i (fetch_mmode),
        .fetch_kill_o  (fetch_kill),
        .data_addr_i   (data_addr),
        .data_mmode_i  (data_mmode),
        .data_write_i  (data_write),
        .data_kill_o   (data_kill),
        .fault_clear_i (fault_clear),
        .fault_valid_o (fault_valid),
        .fault_addr_o  (fault_addr),
        .fault_cause_o (fault_cause)
    );

    // Idle accesses are machine mode at address 0, which no test region covers
    task automatic drive_idle();
        csr_addr    = 12'h000;
        csr_wdata   = 32'h0;
        csr_we      = 1'b0;
        csr_mmode   = 1'b1;
        fetch_addr  = '0;
        fetch_mmode = 1'b1;
        data_addr   = '0;
        data_mmode  = 1'b1;
        data_write  = 1'b0;
        fault_clear = 1'b0;
    endtask

    // Inputs change 5 units after the rising edge and hold for the rest of the cycle
    task automatic next_slot();
        @(posedge core_clock);
        #5;
        drive_idle();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("FAILED case %0d: %s = 0x%h, expected 0x%h", cases_run, name, got, expected);
        case_ok = 1'b0;
    endtask

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 40) begin
            @(posedge core_clock);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was not released within 40 cycles");
            aborted = 1'b1;
        end
    endtask

    task automatic wait_for_fault();
        int cycles;
        cycles = 0;
        while (fault_valid !== 1'b1 && cycles < 16) begin
            next_slot();
            cycles++;
        end
        if (fault_valid !== 1'b1) begin
            $display("Case %0d timed out waiting for fault_valid_o", cases_run);
            case_ok = 1'b0;
        end
    endtask

    task automatic run_case();
        string name;
        case_ok = 1'b1;
        cases_run++;
        next_slot();
        case (op)
            32'd1: begin
                name      = "csr write";
                csr_addr  = col1[11:0];
                csr_wdata = col2;
                csr_mmode = col3[0];
                csr_we    = 1'b1;
            end
            32'd2: begin
                name      = "csr read";
                csr_addr  = col1[11:0];
                csr_mmode = col2[0];
                #25;
                if (csr_rdata !== col3) report_mismatch("csr_rdata_o", csr_rdata, col3);
                if (csr_exists !== col4[0]) report_mismatch("csr_exists_o", 32'(csr_exists), col4);
            end
            32'd3: begin
                name        = "fetch check";
                fetch_addr  = col1[`PMP_ADDR_BITS-1:0];
                fetch_mmode = col2[0];
                #25;
                if (fetch_kill !== col3[0]) report_mismatch("fetch_kill_o", 32'(fetch_kill), col3);
            end
            32'd4: begin
                name       = "data check";
                data_addr  = col1[`PMP_ADDR_BITS-1:0];
                data_mmode = col2[0];
                data_write = col3[0];
                #25;
                if (data_kill !== col4[0]) report_mismatch("data_kill_o", 32'(data_kill), col4);
            end
            32'd5: begin
                name = "fault check";
                if (col1[0]) wait_for_fault();
                #25;
                if (fault_valid !== col1[0]) begin
                    report_mismatch("fault_valid_o", 32'(fault_valid), col1);
                end
                if (col1[0] && fault_addr !== col2[`PMP_ADDR_BITS-1:0]) begin
                    report_mismatch("fault_addr_o", 32'(fault_addr), col2);
                end
                if (col1[0] && fault_cause !== col3[1:0]) begin
                    report_mismatch("fault_cause_o", 32'(fault_cause), col3);
                end
            end
            32'd6: begin
                name        = "fault clear";
                fault_clear = 1'b1;
            end
            default: begin
                name = "unknown";
                $display("Case %0d has an unknown operation code %0h", cases_run, op);
                case_ok = 1'b0;
            end
        endcase
        if (case_ok) begin
            $display("case %0d %s ok", cases_run, name);
        end else begin
            cases_failed++;
            $display("case %0d %s failed", cases_run, name);
        end
    endtask

    initial begin
        cases_run    = 0;
        cases_failed = 0;
        aborted      = 1'b0;
        drive_idle();
        wait_for_reset();
        if (!aborted) begin
            fd = $fopen("tb/pmp_cases.txt", "r");
            if (fd == 0) begin
                $display("Could not open tb/pmp_cases.txt");
                aborted = 1'b1;
            end else begin
                while ($fgets(line, fd) != 0) begin
                    // Blank lines and lines starting with # carry no case
                    if (line.len() > 1 && line[0] != "#") begin
                        fields = $sscanf(line, "%h %h %h %h %h", op, col1, col2, col3, col4);
                        if (fields == 5) begin
                            run_case();
                        end else begin
                            $display("Malformed line in the cases file: %s", line);
                            aborted = 1'b1;
                        end
                    end
                end
                $fclose(fd);
            end
        end
        $display("%0d cases run, %0d passed, %0d failed",
                 cases_run, cases_run - cases_failed, cases_failed);
        if (!aborted && cases_failed == 0 && cases_run > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/pmp_clock_gen.sv
`default_nettype none

module pmp_clock_gen #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic core_clock_o,
    output logic rst_n_o
);

    initial begin
        core_clock_o = 1'b0;
        forever #HALF_PERIOD core_clock_o = ~core_clock_o;
    end

    // Reset is let go a little after a rising edge, like all other stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge core_clock_o);
        #5;
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- design/pmp_unit.sv
`default_nettype none
`include "pmp_settings.svh"

module pmp_unit
    import pmp_pkg::*;
(
    input  wire logic                        core_clock_i,
    input  wire logic                        rst_n_i,

    input  wire logic [11:0]                 csr_addr_i,
    input  wire logic [31:0]                 csr_wdata_i,
    input  wire logic                        csr_we_i,
    input  wire logic                        csr_mmode_i,
    output logic      [31:0]                 csr_rdata_o,
    output logic                             csr_exists_o,

    input  wire logic [`PMP_ADDR_BITS-1:0]   fetch_addr_i,
    input  wire logic                        fetch_mmode_i,
    output logic                             fetch_kill_o,

    input  wire logic [`PMP_ADDR_BITS-1:0]   data_addr_i,
    input  wire logic                        data_mmode_i,
    input  wire logic                        data_write_i,
    output logic                             data_kill_o,

    input  wire logic                        fault_clear_i,
    output logic                             fault_valid_o,
    output logic      [`PMP_ADDR_BITS-1:0]   fault_addr_o,
    output pmp_cause_t                       fault_cause_o
);

    pmp_perm_t [`PMP_ENTRIES-1:0]                     entry_perm;
    logic      [`PMP_ENTRIES-1:0][`PMP_ADDR_BITS-1:0] entry_mask;
    logic      [`PMP_ENTRIES-1:0][`PMP_ADDR_BITS-1:0] entry_match;
    logic                                             fetch_kill;
    logic                                             data_kill;

    pmp_csr_file u_csr_file (
        .core_clock_i  (core_clock_i),
        .rst_n_i       (rst_n_i),
        .csr_addr_i    (csr_addr_i),
        .csr_wdata_i   (csr_wdata_i),
        .csr_we_i      (csr_we_i),
        .csr_mmode_i   (csr_mmode_i),
        .csr_rdata_o   (csr_rdata_o),
        .csr_exists_o  (csr_exists_o),
        .entry_perm_o  (entry_perm),
        .entry_mask_o  (entry_mask),
        .entry_match_o (entry_match)
    );

    pmp_access_check u_access_check (
        .fetch_addr_i  (fetch_addr_i),
        .fetch_mmode_i (fetch_mmode_i),
        .data_addr_i   (data_addr_i),
        .data_mmode_i  (data_mmode_i),
        .data_write_i  (data_write_i),
        .entry_perm_i  (entry_perm),
        .entry_mask_i  (entry_mask),
        .entry_match_i (entry_match),
        .fetch_kill_o  (fetch_kill),
        .data_kill_o   (data_kill)
    );

    // The core sees the kills directly while the recorder samples them
    assign fetch_kill_o = fetch_kill;
    assign data_kill_o  = data_kill;

    pmp_fault_recorder u_fault_recorder (
        .core_clock_i  (core_clock_i),
        .rst_n_i       (rst_n_i),
        .fetch_kill_i  (fetch_kill),
        .fetch_addr_i  (fetch_addr_i),
        .data_kill_i   (data_kill),
        .data_addr_i   (data_addr_i),
        .data_write_i  (data_write_i),
        .fault_clear_i (fault_clear_i),
        .fault_valid_o (fault_valid_o),
        .fault_addr_o  (fault_addr_o),
        .fault_cause_o (fault_cause_o)
    );

endmodule

`default_nettype wire

//--- design/pmp_fault_recorder.sv
`default_nettype none
`include "pmp_settings.svh"

module pmp_fault_recorder
    import pmp_pkg::*;
(
    input  wire logic                        core_clock_i,
    input  wire logic                        rst_n_i,
    input  wire logic                        fetch_kill_i,
    input  wire logic [`PMP_ADDR_BITS-1:0]   fetch_addr_i,
    input  wire logic                        data_kill_i,
    input  wire logic [`PMP_ADDR_BITS-1:0]   data_addr_i,
    input  wire logic                        data_write_i,
    input  wire logic                        fault_clear_i,
    output logic                             fault_valid_o,
    output logic      [`PMP_ADDR_BITS-1:0]   fault_addr_o,
    output pmp_cause_t                       fault_cause_o
);

    logic capture;

    // A held record is only replaced when software clears it in the same cycle
    assign capture = (fetch_kill_i || data_kill_i) && (!fault_valid_o || fault_clear_i);

    always_ff @(posedge core_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fault_valid_o <= 1'b0;
        end else if (capture) begin
            fault_valid_o <= 1'b1;
        end else if (fault_clear_i) begin
            fault_valid_o <= 1'b0;
        end
    end

    // Fetch side wins when both kill together
    always_ff @(posedge core_clock_i) begin
        if (capture) begin
            if (fetch_kill_i) begin
                fault_addr_o  <= fetch_addr_i;
                fault_cause_o <= PMP_CAUSE_FETCH;
            end else begin
                fault_addr_o  <= data_addr_i;
                fault_cause_o <= data_write_i ? PMP_CAUSE_STORE : PMP_CAUSE_LOAD;
            end
        end
    end

    assert property (@(posedge core_clock_i) disable iff (!rst_n_i)
        (fault_valid_o && !fault_clear_i)
            |=> fault_valid_o && $stable(fault_cause_o) && $stable(fault_addr_o))
    else $error("pmp_fault_recorder: held fault record changed");

endmodule

`default_nettype wire

//--- design/pmp_access_check.sv
`default_nettype none
`include "pmp_settings.svh"

module pmp_access_check
    import pmp_pkg::*;
(
    input  wire logic      [`PMP_ADDR_BITS-1:0]                   fetch_addr_i,
    input  wire logic                                             fetch_mmode_i,
    input  wire logic      [`PMP_ADDR_BITS-1:0]                   data_addr_i,
    input  wire logic                                             data_mmode_i,
    input  wire logic                                             data_write_i,
    input  wire pmp_perm_t [`PMP_ENTRIES-1:0]                     entry_perm_i,
    input  wire logic      [`PMP_ENTRIES-1:0][`PMP_ADDR_BITS-1:0] entry_mask_i,
    input  wire logic      [`PMP_ENTRIES-1:0][`PMP_ADDR_BITS-1:0] entry_match_i,
    output logic                                                  fetch_kill_o,
    output logic                                                  data_kill_o
);

    logic      fetch_hit;
    pmp_perm_t fetch_perm;
    logic      data_hit;
    pmp_perm_t data_perm;
    logic      data_allowed;

    pmp_region_matcher u_fetch_match (
        .addr_i        (fetch_addr_i),
        .entry_perm_i  (entry_perm_i),
        .entry_mask_i  (entry_mask_i),
        .entry_match_i (entry_match_i),
        .hit_o         (fetch_hit),
        .perm_o        (fetch_perm)
    );

    pmp_region_matcher u_data_match (
        .addr_i        (data_addr_i),
        .entry_perm_i  (entry_perm_i),
        .entry_mask_i  (entry_mask_i),
        .entry_match_i (entry_match_i),
        .hit_o         (data_hit),
        .perm_o        (data_perm)
    );

    // Machine mode is only restricted by locked entries, user mode needs an explicit grant
    assign fetch_kill_o = fetch_mmode_i ? (fetch_hit && fetch_perm.locked && !fetch_perm.execute)
                                        : !(fetch_hit && fetch_perm.execute);

    assign data_allowed = data_write_i ? data_perm.write : data_perm.read;

    assign data_kill_o = data_mmode_i ? (data_hit && data_perm.locked && !data_allowed)
                                      : !(data_hit && data_allowed);

endmodule

`default_nettype wire

//--- design/pmp_region_matcher.sv
`default_nettype none
`include "pmp_settings.svh"

module pmp_region_matcher
    import pmp_pkg::*;
(
    input  wire logic      [`PMP_ADDR_BITS-1:0]                   addr_i,
    input  wire pmp_perm_t [`PMP_ENTRIES-1:0]                     entry_perm_i,
    input  wire logic      [`PMP_ENTRIES-1:0][`PMP_ADDR_BITS-1:0] entry_mask_i,
    input  wire logic      [`PMP_ENTRIES-1:0][`PMP_ADDR_BITS-1:0] entry_match_i,
    output logic                                                  hit_o,
    output pmp_perm_t                                             perm_o
);

    logic [`PMP_ENTRIES-1:0] entry_hit;

    // Every enabled entry compares in parallel
    always_comb begin
        for (int i = 0; i < `PMP_ENTRIES; i++) begin
            entry_hit[i] = entry_perm_i[i].enabled
                           && ((addr_i & entry_mask_i[i]) == entry_match_i[i]);
        end
    end

    assign hit_o = |entry_hit;

    // Walk from the top so the lowest-numbered hit is the last to assign
    always_comb begin
        perm_o = '0;
        for (int i = `PMP_ENTRIES - 1; i >= 0; i--) begin
            if (entry_hit[i]) begin
                perm_o = entry_perm_i[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/pmp_csr_file.sv
`default_nettype none
`include "pmp_settings.svh"

module pmp_csr_file
    import pmp_pkg::*;
(
    input  wire logic                                    core_clock_i,
    input  wire logic                                    rst_n_i,
    input  wire logic [11:0]                             csr_addr_i,
    input  wire logic [31:0]                             csr_wdata_i,
    input  wire logic                                    csr_we_i,
    input  wire logic                                    csr_mmode_i,
    output logic      [31:0]                             csr_rdata_o,
    output logic                                         csr_exists_o,
    output pmp_perm_t [`PMP_ENTRIES-1:0]                 entry_perm_o,
    output logic      [`PMP_ENTRIES-1:0][`PMP_ADDR_BITS-1:0] entry_mask_o,
    output logic      [`PMP_ENTRIES-1:0][`PMP_ADDR_BITS-1:0] entry_match_o
);

    pmp_perm_t [`PMP_ENTRIES-1:0]                       perm_q;
    logic      [`PMP_ENTRIES-1:0][25:0]                 addr_q;
    logic      [`PMP_ENTRIES-1:0][`PMP_ADDR_BITS-1:0]   mask_q;
    logic      [`PMP_ENTRIES-1:0][`PMP_ADDR_BITS-1:0]   match_q;

    logic                                               wr_ok;
    logic [`PMP_CFG_REGS-1:0]                           cfg_wr_sel;
    logic [`PMP_ENTRIES-1:0]                            addr_wr_sel;
    logic [`PMP_ADDR_BITS-1:0]                          dec_mask;
    logic [`PMP_ADDR_BITS-1:0]                          dec_match;
    logic                                               cfg_range;
    logic                                               addr_range;
    logic [31:0]                                        cfg_rdata;
    logic [31:0]                                        addr_rdata;

    initial begin
        if ((`PMP_ENTRIES == 0) || (`PMP_ENTRIES % 4 != 0) || (`PMP_ENTRIES > 16)) begin
            $fatal(1, "pmp_csr_file: PMP_ENTRIES must be 4, 8, 12 or 16");
        end
    end

    function automatic pmp_perm_t cfg_to_perm(input logic [7:0] cfg);
        pmp_perm_t perm;
        // Only A = 2'b11 (NAPOT) turns an entry on
        perm.enabled = &cfg[4:3];
        perm.locked  = cfg[7];
        perm.execute = cfg[2];
        perm.write   = cfg[1];
        perm.read    = cfg[0];
        return perm;
    endfunction

    function automatic logic [7:0] perm_to_cfg(input pmp_perm_t perm);
        return {perm.locked, 2'b00, {2{perm.enabled}}, perm.execute, perm.write, perm.read};
    endfunction

    assign wr_ok = csr_we_i && csr_mmode_i;

    for (genvar n = 0; n < `PMP_CFG_REGS; n++) begin : g_cfg_sel
        assign cfg_wr_sel[n] = wr_ok && (csr_addr_i == `PMP_CSR_CFG_BASE + 12'(n));
    end

    for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : g_addr_sel
        assign addr_wr_sel[i] = wr_ok && (csr_addr_i == `PMP_CSR_ADDR_BASE + 12'(i));
    end

    // The low four pmpaddr bits are forced to ones, which sets the 128 byte minimum
    pmp_napot_decoder u_decoder (
        .addr_i  ({csr_wdata_i[29:4], 4'b1111}),
        .mask_o  (dec_mask),
        .match_o (dec_match)
    );

    always_ff @(posedge core_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            perm_q <= '0;
        end else begin
            for (int i = 0; i < `PMP_ENTRIES; i++) begin
                if (cfg_wr_sel[i / 4] && !perm_q[i].locked) begin
                    perm_q[i] <= cfg_to_perm(csr_wdata_i[8 * (i % 4) +: 8]);
                end
            end
        end
    end

    // Mask and match are decoded once at write time to keep the check path short
    always_ff @(posedge core_clock_i) begin
        for (int i = 0; i < `PMP_ENTRIES; i++) begin
            if (addr_wr_sel[i] && !perm_q[i].locked) begin
                addr_q[i]  <= csr_wdata_i[29:4];
                mask_q[i]  <= dec_mask;
                match_q[i] <= dec_match;
            end
        end
    end

    always_comb begin
        cfg_rdata = '0;
        for (int n = 0; n < `PMP_CFG_REGS; n++) begin
            if (csr_addr_i == `PMP_CSR_CFG_BASE + 12'(n)) begin
                for (int j = 0; j < 4; j++) begin
                    cfg_rdata[8 * j +: 8] = perm_to_cfg(perm_q[4 * n + j]);
                end
            end
        end
    end

    always_comb begin
        addr_rdata = '0;
        for (int i = 0; i < `PMP_ENTRIES; i++) begin
            if (csr_addr_i == `PMP_CSR_ADDR_BASE + 12'(i)) begin
                addr_rdata = {2'b00, addr_q[i], 4'b1111};
            end
        end
    end

    // Unimplemented registers inside both ranges exist and read as zero
    assign cfg_range  = (csr_addr_i >= `PMP_CSR_CFG_BASE) && (csr_addr_i < `PMP_CSR_ADDR_BASE);
    assign addr_range = (csr_addr_i >= `PMP_CSR_ADDR_BASE) && (csr_addr_i < `PMP_CSR_ADDR_END);

    assign csr_exists_o = (cfg_range || addr_range) && csr_mmode_i;
    assign csr_rdata_o  = cfg_range ? cfg_rdata : addr_rdata;

    assign entry_perm_o  = perm_q;
    assign entry_mask_o  = mask_q;
    assign entry_match_o = match_q;

    for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : g_lock_chk
        assert property (@(posedge core_clock_i) disable iff (!rst_n_i)
            perm_q[i].locked |=> $stable(perm_q[i]) && $stable(addr_q[i])
                                 && $stable(mask_q[i]) && $stable(match_q[i]))
        else $error("pmp_csr_file: locked entry %0d was modified", i);
    end

endmodule

`default_nettype wire

//--- design/pmp_napot_decoder.sv
`default_nettype none
`include "pmp_settings.svh"

module pmp_napot_decoder (
    input  wire logic [29:0]                addr_i,
    output logic      [`PMP_ADDR_BITS-1:0]  mask_o,
    output logic      [`PMP_ADDR_BITS-1:0]  match_o
);

    logic [29:0] low_run;
    logic [29:0] ignored;

    // Adding one flips the trailing ones and the zero just above them,
    // so the XOR marks exactly the bits a NAPOT region ignores
    assign low_run = addr_i ^ (addr_i + 30'd1);

    // Keep only pmpaddr bits 29:5, which line up with address bits 31:7
    assign mask_o  = ~low_run[29:5];
    assign match_o = addr_i[29:5] & mask_o;

    // Pmpaddr bits 4:0 have no compare bit and always count as ignored
    assign ignored = {~mask_o, 5'b11111};

    // The ignored bits must be the trailing ones of pmpaddr and the zero just above them
    always_comb begin
        assert ((&addr_i) || ((addr_i & ignored) == (ignored >> 1)))
        else $error("pmp_napot_decoder: mask %h does not fit pmpaddr %h", mask_o, addr_i);
    end

endmodule

`default_nettype wire

//--- design/pmp_pkg.sv
`default_nettype none

package pmp_pkg;

    // Decoded permission bits of one PMP entry
    typedef struct packed {
        logic enabled;
        logic locked;
        logic execute;
        logic write;
        logic read;
    } pmp_perm_t;

    // Kind of access that caused a recorded fault
    typedef enum logic [1:0] {
        PMP_CAUSE_FETCH = 2'd0,
        PMP_CAUSE_LOAD  = 2'd1,
        PMP_CAUSE_STORE = 2'd2
    } pmp_cause_t;

endpackage

`default_nettype wire

//--- design/pmp_settings.svh
`ifndef PMP_SETTINGS_SVH
`define PMP_SETTINGS_SVH

// Number of PMP entries, a nonzero multiple of 4 and no more than 16
`define PMP_ENTRIES 8

// Each pmpcfg register carries four entries
`define PMP_CFG_REGS (`PMP_ENTRIES / 4)

// Checked physical address bits 31:7, so regions are at least 128 bytes
`define PMP_ADDR_BITS 25

// CSR address map
`define PMP_CSR_CFG_BASE 12'h3a0
`define PMP_CSR_ADDR_BASE 12'h3b0
`define PMP_CSR_ADDR_END 12'h3f0

`endif
